//--- src/board_pkg.sv
/*
 * Board package
 * Switch and key counts, decoded configuration, pressed keys,
 * drive activity bits and seven-segment types of the board glue.
 */

package board_pkg;

  localparam int SW_W  = 10;                // Slide switches SW9..SW0
  localparam int KEY_W = 4;                 // Push buttons KEY3..KEY0

  // Decoded switch configuration, SW9 down to SW1
  typedef struct packed {
    logic       scan_15khz;                 // SW9, scandoubler off
    logic       joy_emu;                    // SW8, keyboard joystick
    logic       audio_swap;                 // SW7, exchange channels
    logic       audio_center;               // SW6, centered mix
    logic       uart_ctrl;                  // SW5, UART to ctrl cpu
    logic [3:0] ctrl_cfg;                   // SW4..SW1
  } board_cfg_t;

  // Pressed keys, active high
  typedef struct packed {
    logic mouse_btn1;                       // KEY3
    logic mouse_btn2;                       // KEY2
    logic aux;                              // KEY1
    logic reset_req;                        // KEY0
  } keys_t;

  // Drive FIFO activity
  typedef struct packed {
    logic floppy_wr;
    logic floppy_rd;
    logic hd_wr;
    logic hd_rd;
  } drive_act_t;

  typedef logic [6:0] seg7_t;               // Active low, gfedcba

endpackage

//--- src/audio_pkg.sv
/*
 * Audio package
 * Sample widths, stereo pair, mix mode and the handshake states
 * of the sample intake.
 */

package audio_pkg;

  localparam int SAMPLE_W = 15;             // Core DAC sample width

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [SAMPLE_W:0]   out_sample_t;  // One bit of headroom for the mix

  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  // Bit 1 centered mix, bit 0 channel exchange
  typedef enum logic [1:0] {
    MIX_STEREO      = 2'd0,
    MIX_SWAP        = 2'd1,
    MIX_CENTER      = 2'd2,
    MIX_SWAP_CENTER = 2'd3
  } mix_mode_e;

  typedef enum logic {
    HS_IDLE = 1'b0,                         // Waiting for req
    HS_ACK  = 1'b1                          // Ack up, waiting for req low
  } hs_state_e;

endpackage

//--- src/board_controls.sv
/*
 * Board controls
 * Synchronizes switches and keys into clk_28, decodes them into
 * the configuration and key structs and the audio mix mode, and
 * routes the shared UART and the SPI data-in line.
 */

`timescale 1ns/1ps

module board_controls #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                          clk_28,
  input  logic                          arst_n,
  input  logic [board_pkg::SW_W-1:0]    sw,
  input  logic [board_pkg::KEY_W-1:0]   key,          // Active low
  input  logic                          ctrl_txd,
  input  logic                          minimig_txd,
  input  logic                          uart_rxd,
  input  logic                          sd_dat,
  input  logic                          sd_cs_n,
  input  logic                          sdo,
  output board_pkg::board_cfg_t         cfg,
  output board_pkg::keys_t              keys,
  output audio_pkg::mix_mode_e          mix_mode,
  output logic                          uart_txd,
  output logic                          minimig_rxd,
  output logic                          spi_di
);

  localparam int SYNC_W = board_pkg::SW_W - 1 + board_pkg::KEY_W;  // SW0 unused here

  logic [SYNC_W-1:0] sync_q [SYNC_STAGES];    // Stage 0 is the metastable one

  //////////////////////////////////////////////////////////////////////
  // Synchronizer chain
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;                      // All off and nothing pressed
      end
    end else begin
      sync_q[0] <= {sw[board_pkg::SW_W-1:1], ~key};  // Keys to active high
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Field order follows the switch and key numbering
  assign cfg  = board_pkg::board_cfg_t'(sync_q[SYNC_STAGES-1][SYNC_W-1:board_pkg::KEY_W]);
  assign keys = board_pkg::keys_t'(sync_q[SYNC_STAGES-1][board_pkg::KEY_W-1:0]);

  always_comb begin
    case ({cfg.audio_center, cfg.audio_swap})
      2'b01:   mix_mode = audio_pkg::MIX_SWAP;
      2'b10:   mix_mode = audio_pkg::MIX_CENTER;
      2'b11:   mix_mode = audio_pkg::MIX_SWAP_CENTER;
      default: mix_mode = audio_pkg::MIX_STEREO;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Serial routing
  //////////////////////////////////////////////////////////////////////

  assign uart_txd    = cfg.uart_ctrl ? ctrl_txd : minimig_txd;  // TX owner
  assign minimig_rxd = cfg.uart_ctrl ? 1'b1 : uart_rxd;         // Idle high when not routed
  assign spi_di      = !sd_cs_n ? sd_dat : sdo;                 // Card drives MISO when selected

  // Swap and center in the mix mode follow the audio switches
  a_mix_mode: assert property (@(posedge clk_28) disable iff (!arst_n)
    (mix_mode inside {audio_pkg::MIX_SWAP, audio_pkg::MIX_SWAP_CENTER}) == cfg.audio_swap &&
    (mix_mode inside {audio_pkg::MIX_CENTER, audio_pkg::MIX_SWAP_CENTER}) == cfg.audio_center);

endmodule

//--- src/reset_seq.sv
/*
 * CPU reset sequencer
 * Holds the core CPU in reset while the PLL is unlocked or KEY0
 * is pressed, then keeps it there for RESET_HOLD more cycles.
 */

`timescale 1ns/1ps

module reset_seq #(
  parameter int RESET_HOLD = 32
) (
  input  logic clk_28,
  input  logic arst_n,
  input  logic pll_locked,
  input  logic reset_req,                   // Synchronized KEY0
  output logic cpu_reset_n
);

  localparam int CNT_W = $clog2(RESET_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             hold;

  assign hold = !pll_locked || reset_req;   // Any reason to keep reset

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      hold_cnt    <= CNT_W'(RESET_HOLD);
      cpu_reset_n <= 1'b0;
    end else if (hold) begin
      hold_cnt    <= CNT_W'(RESET_HOLD);    // Restart the count
      cpu_reset_n <= 1'b0;
    end else begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      if (hold_cnt <= CNT_W'(1)) begin
        cpu_reset_n <= 1'b1;                // Counter hits zero this edge
      end
    end
  end

  // PLL loss reaches the CPU reset on the next edge
  a_pll_reset: assert property (@(posedge clk_28) disable iff (!arst_n)
    !pll_locked |=> !cpu_reset_n);

endmodule

//--- src/audio_mixer.sv
/*
 * Audio mixer
 * Takes left/right samples over a four-phase req/ack handshake,
 * applies channel exchange and the centered mix, and holds the
 * result in the output registers.
 */

`timescale 1ns/1ps

module audio_mixer (
  input  logic                   clk_28,
  input  logic                   arst_n,
  input  audio_pkg::mix_mode_e   mix_mode,
  input  logic                   sample_req,
  input  audio_pkg::stereo_t     sample_in,
  output logic                   sample_ack,
  output audio_pkg::out_sample_t left_out,
  output audio_pkg::out_sample_t right_out
);

  audio_pkg::hs_state_e  state;
  audio_pkg::sample_t    own_l, own_r;      // Samples after routing
  audio_pkg::out_sample_t mix_l, mix_r;
  logic                  swap, center;
  logic                  capture;

  //////////////////////////////////////////////////////////////////////
  // Mix datapath
  //////////////////////////////////////////////////////////////////////

  assign swap   = mix_mode inside {audio_pkg::MIX_SWAP, audio_pkg::MIX_SWAP_CENTER};
  assign center = mix_mode inside {audio_pkg::MIX_CENTER, audio_pkg::MIX_SWAP_CENTER};

  assign own_l = swap ? sample_in.right : sample_in.left;
  assign own_r = swap ? sample_in.left  : sample_in.right;

  // Half of the opposite channel bleeds in, sum fits one extra bit
  always_comb begin
    mix_l = audio_pkg::out_sample_t'(own_l);                 // Sign extend
    mix_r = audio_pkg::out_sample_t'(own_r);
    if (center) begin
      mix_l = mix_l + audio_pkg::out_sample_t'(own_r >>> 1);
      mix_r = mix_r + audio_pkg::out_sample_t'(own_l >>> 1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////////////////////////

  assign capture = (state == audio_pkg::HS_IDLE) && sample_req;

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      state      <= audio_pkg::HS_IDLE;
      sample_ack <= 1'b0;
    end else begin
      case (state)
        audio_pkg::HS_IDLE: if (sample_req) begin
          state      <= audio_pkg::HS_ACK;
          sample_ack <= 1'b1;               // Sample taken
        end
        audio_pkg::HS_ACK: if (!sample_req) begin
          state      <= audio_pkg::HS_IDLE;
          sample_ack <= 1'b0;               // Ready for the next one
        end
        default: begin
          state      <= audio_pkg::HS_IDLE;
          sample_ack <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      left_out  <= '0;
      right_out <= '0;
    end else if (capture) begin
      left_out  <= mix_l;                   // Only on the ack rising edge
      right_out <= mix_r;
    end
  end

  a_ack_state: assert property (@(posedge clk_28) disable iff (!arst_n)
    sample_ack |-> state == audio_pkg::HS_ACK);

  // Outputs hold for the whole ack phase
  a_out_stable: assert property (@(posedge clk_28) disable iff (!arst_n)
    sample_ack && $past(sample_ack) |-> $stable(left_out) && $stable(right_out));

endmodule

//--- src/status_display.sv
/*
 * Status display
 * Shows the floppy track number on two hex digits and stretches
 * the drive FIFO activity pulses so they are visible on the LEDs.
 */

`timescale 1ns/1ps

module status_display #(
  parameter int STRETCH_CYCLES = 64
) (
  input  logic                  clk_28,
  input  logic                  arst_n,
  input  logic [7:0]            track,
  input  board_pkg::drive_act_t drive_act,
  output board_pkg::seg7_t      hex0,
  output board_pkg::seg7_t      hex1,
  output board_pkg::drive_act_t led_g
);

  localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

  logic [3:0] act_vec;
  logic [3:0] led_vec;

  // Nibble to active-low segments
  function automatic board_pkg::seg7_t hex_seg(input logic [3:0] nib);
    case (nib)
      4'h0:    hex_seg = 7'h40;
      4'h1:    hex_seg = 7'h79;
      4'h2:    hex_seg = 7'h24;
      4'h3:    hex_seg = 7'h30;
      4'h4:    hex_seg = 7'h19;
      4'h5:    hex_seg = 7'h12;
      4'h6:    hex_seg = 7'h02;
      4'h7:    hex_seg = 7'h78;
      4'h8:    hex_seg = 7'h00;
      4'h9:    hex_seg = 7'h10;
      4'ha:    hex_seg = 7'h08;
      4'hb:    hex_seg = 7'h03;             // Lower case b
      4'hc:    hex_seg = 7'h46;
      4'hd:    hex_seg = 7'h21;             // Lower case d
      4'he:    hex_seg = 7'h06;
      default: hex_seg = 7'h0e;             // F
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Track digits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28 or negedge arst_n) begin
    if (!arst_n) begin
      hex0 <= hex_seg(4'h0);                // Shows 00 out of reset
      hex1 <= hex_seg(4'h0);
    end else begin
      hex0 <= hex_seg(track[3:0]);
      hex1 <= hex_seg(track[7:4]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Activity stretchers
  //////////////////////////////////////////////////////////////////////

  assign act_vec = drive_act;

  for (genvar i = 0; i < 4; i++) begin : g_stretch
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk_28 or negedge arst_n) begin
      if (!arst_n) begin
        cnt <= '0;
      end else if (act_vec[i]) begin
        cnt <= CNT_W'(STRETCH_CYCLES);      // Retrigger on every pulse
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end

    assign led_vec[i] = (cnt != '0);

    a_cnt_max: assert property (@(posedge clk_28) disable iff (!arst_n)
      cnt <= CNT_W'(STRETCH_CYCLES));
  end

  assign led_g = board_pkg::drive_act_t'(led_vec);

endmodule

//--- src/minimig_board.sv
/*
 * Minimig board glue, top level
 * Control synchronization, serial routing, CPU reset sequencing,
 * audio mixing and the status display of the DE1 board.
 */

`timescale 1ns/1ps

module minimig_board #(
  parameter int SYNC_STAGES    = 2,
  parameter int RESET_HOLD     = 32,
  parameter int STRETCH_CYCLES = 64
) (
  input  logic                          clk_28,
  input  logic                          arst_n,
  // Switches, keys, PLL
  input  logic [board_pkg::SW_W-1:0]    sw,
  input  logic [board_pkg::KEY_W-1:0]   key,          // Active low
  input  logic                          pll_locked,
  // UART
  input  logic                          uart_rxd,
  output logic                          uart_txd,
  input  logic                          ctrl_txd,
  input  logic                          minimig_txd,
  output logic                          minimig_rxd,
  // SPI data in
  input  logic                          sd_dat,
  input  logic                          sd_cs_n,
  input  logic                          sdo,
  output logic                          spi_di,
  // Audio samples
  input  logic                          sample_req,
  input  audio_pkg::stereo_t            sample_in,
  output logic                          sample_ack,
  output audio_pkg::out_sample_t        left_out,
  output audio_pkg::out_sample_t        right_out,
  // Indicators
  input  logic [7:0]                    track,
  input  board_pkg::drive_act_t         drive_act,
  output board_pkg::seg7_t              hex0,
  output board_pkg::seg7_t              hex1,
  output board_pkg::drive_act_t         led_g,
  // Decoded controls and CPU reset
  output board_pkg::board_cfg_t         cfg,
  output board_pkg::keys_t              keys,
  output logic                          cpu_reset_n
);

  audio_pkg::mix_mode_e mix_mode;           // From the audio switches

  board_controls #(.SYNC_STAGES(SYNC_STAGES)) u_controls (
    .clk_28      (clk_28      ),
    .arst_n      (arst_n      ),
    .sw          (sw          ),
    .key         (key         ),
    .ctrl_txd    (ctrl_txd    ),
    .minimig_txd (minimig_txd ),
    .uart_rxd    (uart_rxd    ),
    .sd_dat      (sd_dat      ),
    .sd_cs_n     (sd_cs_n     ),
    .sdo         (sdo         ),
    .cfg         (cfg         ),
    .keys        (keys        ),
    .mix_mode    (mix_mode    ),
    .uart_txd    (uart_txd    ),
    .minimig_rxd (minimig_rxd ),
    .spi_di      (spi_di      )
  );

  reset_seq #(.RESET_HOLD(RESET_HOLD)) u_reset (
    .clk_28      (clk_28        ),
    .arst_n      (arst_n        ),
    .pll_locked  (pll_locked    ),
    .reset_req   (keys.reset_req),          // KEY0
    .cpu_reset_n (cpu_reset_n   )
  );

  audio_mixer u_audio (
    .clk_28      (clk_28      ),
    .arst_n      (arst_n      ),
    .mix_mode    (mix_mode    ),
    .sample_req  (sample_req  ),
    .sample_in   (sample_in   ),
    .sample_ack  (sample_ack  ),
    .left_out    (left_out    ),
    .right_out   (right_out   )
  );

  status_display #(.STRETCH_CYCLES(STRETCH_CYCLES)) u_display (
    .clk_28      (clk_28      ),
    .arst_n      (arst_n      ),
    .track       (track       ),
    .drive_act   (drive_act   ),
    .hex0        (hex0        ),
    .hex1        (hex1        ),
    .led_g       (led_g       )
  );

endmodule

//--- bench/tb_minimig_board.sv
/*
 * Minimig board glue testbench
 * LFSR stimulus on the top level, checked against a local model of
 * reset sequencing, control sync, serial routing, audio and display.
 */

`timescale 1ns/1ps

module tb_minimig_board;

  localparam int SYNC_STAGES    = 2;
  localparam int RESET_HOLD     = 32;
  localparam int STRETCH_CYCLES = 64;
  localparam int WAIT_LIMIT     = 200;      // Cycles before a wait gives up

  // Lit segments, gfedcba, for digits 0..F
  localparam logic [6:0] SEG_ON [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  logic                        clk_28 = 1'b0;
  logic                        arst_n;
  logic [board_pkg::SW_W-1:0]  sw;
  logic [board_pkg::KEY_W-1:0] key;
  logic                        pll_locked, uart_rxd, uart_txd, ctrl_txd, minimig_txd;
  logic                        minimig_rxd, sd_dat, sd_cs_n, sdo, spi_di;
  logic                        sample_req, sample_ack, cpu_reset_n;
  audio_pkg::stereo_t          sample_in;
  audio_pkg::out_sample_t      left_out, right_out;
  logic [7:0]                  track;
  board_pkg::drive_act_t       drive_act, led_g;
  board_pkg::seg7_t            hex0, hex1;
  board_pkg::board_cfg_t       cfg;
  board_pkg::keys_t            keys;
  logic [15:0]                 lfsr_state = 16'd3;  // Seed

  minimig_board #(
    .SYNC_STAGES(SYNC_STAGES), .RESET_HOLD(RESET_HOLD), .STRETCH_CYCLES(STRETCH_CYCLES)
  ) DUT (
    .clk_28(clk_28), .arst_n(arst_n), .sw(sw), .key(key), .pll_locked(pll_locked),
    .uart_rxd(uart_rxd), .uart_txd(uart_txd), .ctrl_txd(ctrl_txd),
    .minimig_txd(minimig_txd), .minimig_rxd(minimig_rxd), .sd_dat(sd_dat),
    .sd_cs_n(sd_cs_n), .sdo(sdo), .spi_di(spi_di), .sample_req(sample_req),
    .sample_in(sample_in), .sample_ack(sample_ack), .left_out(left_out),
    .right_out(right_out), .track(track), .drive_act(drive_act), .hex0(hex0),
    .hex1(hex1), .led_g(led_g), .cfg(cfg), .keys(keys), .cpu_reset_n(cpu_reset_n)
  );

  always #5 clk_28 = ~clk_28;               // 100 MHz stand-in for clk_28

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];     // x^16 + x^14 + x^13 + x^11 + 1
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);   // One step per bit
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at time %0t: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  // Counts edges from the current one until ack reaches the level
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_28);
      @(negedge clk_28);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("Timeout: sample_ack never went to %0b", level));
      end
    end while (sample_ack !== level);
  endtask

  task automatic wait_release(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_28);
      @(negedge clk_28);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: cpu_reset_n was never released");
      end
    end while (cpu_reset_n !== 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic board_pkg::board_cfg_t cfg_from_sw(input logic [board_pkg::SW_W-1:0] s);
    board_pkg::board_cfg_t c;
    c.scan_15khz   = s[9];
    c.joy_emu      = s[8];
    c.audio_swap   = s[7];
    c.audio_center = s[6];
    c.uart_ctrl    = s[5];
    c.ctrl_cfg     = s[4:1];                // SW0 has no use here
    return c;
  endfunction

  function automatic board_pkg::keys_t keys_from_key(input logic [board_pkg::KEY_W-1:0] kv);
    board_pkg::keys_t k;
    k.mouse_btn1 = !kv[3];                  // Buttons pull low when pressed
    k.mouse_btn2 = !kv[2];
    k.aux        = !kv[1];
    k.reset_req  = !kv[0];
    return k;
  endfunction

  function automatic int mix_side(input audio_pkg::sample_t own,
                                  input audio_pkg::sample_t other, input logic center);
    int sum;
    sum = int'(own);
    if (center) begin
      sum = sum + (int'(other) >>> 1);      // Half of the far channel, rounded down
    end
    return sum;
  endfunction

  function automatic board_pkg::seg7_t seg_of(input logic [3:0] nib);
    return ~SEG_ON[nib];                    // Board segments are active low
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                          n;
    logic [31:0]                 r;
    logic [board_pkg::SW_W-1:0]  sw_q [$];
    logic [board_pkg::KEY_W-1:0] key_q [$];
    board_pkg::board_cfg_t       exp_cfg;
    audio_pkg::stereo_t          smp;
    audio_pkg::sample_t          own_l, own_r;
    logic                        swap, center;
    int                          exp_l, exp_r;
    logic [7:0]                  trk_prev;
    logic [3:0]                  act_prev, act_new, exp_led;
    int                          since_last [4];

    arst_n     <= 1'b0;
    sw         <= '0;
    key        <= 4'b1110;                  // KEY0 held down
    pll_locked <= 1'b1;
    uart_rxd   <= 1'b1;
    ctrl_txd   <= 1'b1;
    minimig_txd <= 1'b1;
    sd_dat     <= 1'b1;
    sd_cs_n    <= 1'b1;
    sdo        <= 1'b1;
    sample_req <= 1'b0;
    sample_in  <= '0;
    track      <= '0;
    drive_act  <= '0;

    repeat (15) @(posedge clk_28);
    @(negedge clk_28);
    check(32'(sample_ack), 0, "sample_ack in reset");
    check(32'(cpu_reset_n), 0, "cpu_reset_n in reset");
    check(32'(led_g), 0, "led_g in reset");
    check(int'(left_out), 0, "left_out in reset");
    check(int'(right_out), 0, "right_out in reset");
    check(32'(hex0), 32'(seg_of(4'h0)), "hex0 in reset");
    check(32'(hex1), 32'(seg_of(4'h0)), "hex1 in reset");
    check(32'(cfg), 0, "cfg in reset");
    check(32'(keys), 0, "keys in reset");
    @(posedge clk_28);
    arst_n <= 1'b1;

    // CPU reset from KEY0, PLL loss and a short PLL glitch
    repeat (SYNC_STAGES + 4) @(posedge clk_28);
    @(negedge clk_28);
    check(32'(cpu_reset_n), 0, "cpu_reset_n while KEY0 pressed");
    @(posedge clk_28);
    key <= 4'b1111;
    wait_release(n);
    check(n, SYNC_STAGES + RESET_HOLD, "cycles to release after KEY0");
    @(posedge clk_28);
    pll_locked <= 1'b0;
    @(negedge clk_28);
    check(32'(cpu_reset_n), 1, "cpu_reset_n before PLL loss is seen");
    @(posedge clk_28);
    @(negedge clk_28);
    check(32'(cpu_reset_n), 0, "cpu_reset_n after PLL loss");
    repeat (4) @(posedge clk_28);
    pll_locked <= 1'b1;
    repeat (RESET_HOLD / 2) @(posedge clk_28);
    pll_locked <= 1'b0;                     // Mid-count glitch restarts the hold
    @(posedge clk_28);
    pll_locked <= 1'b1;
    wait_release(n);
    check(n, RESET_HOLD, "cycles to release after PLL relock");

    // Switch and key sync, serial routing
    for (int i = 0; i < SYNC_STAGES; i++) begin
      sw_q.push_back(sw);                   // Values already in the sync chain
      key_q.push_back(key);
    end
    for (int i = 0; i < 150; i++) begin
      @(posedge clk_28);
      r = rand_bits(board_pkg::SW_W);
      sw <= r[board_pkg::SW_W-1:0];
      sw_q.push_back(r[board_pkg::SW_W-1:0]);
      r = rand_bits(board_pkg::KEY_W);
      key <= r[board_pkg::KEY_W-1:0];
      key_q.push_back(r[board_pkg::KEY_W-1:0]);
      r = rand_bits(6);
      {ctrl_txd, minimig_txd, uart_rxd, sd_dat, sd_cs_n, sdo} <= r[5:0];
      @(negedge clk_28);
      exp_cfg = cfg_from_sw(sw_q.pop_front());
      check(32'(cfg), 32'(exp_cfg), "cfg");
      check(32'(keys), 32'(keys_from_key(key_q.pop_front())), "keys");
      check(32'(uart_txd), 32'(exp_cfg.uart_ctrl ? ctrl_txd : minimig_txd), "uart_txd");
      check(32'(minimig_rxd), 32'(exp_cfg.uart_ctrl ? 1'b1 : uart_rxd), "minimig_rxd");
      check(32'(spi_di), 32'(sd_cs_n ? sdo : sd_dat), "spi_di");
    end

    // Audio handshake, 50 samples per mix mode
    for (int m = 0; m < 4; m++) begin
      swap   = m[0];
      center = m[1];
      @(posedge clk_28);
      sw  <= {2'b00, swap, center, 6'b000000};  // SW7 swap, SW6 center
      key <= 4'b1111;
      repeat (SYNC_STAGES + 1) @(posedge clk_28);
      for (int i = 0; i < 50; i++) begin
        r = rand_bits(2);
        repeat (r[1:0]) @(posedge clk_28);  // Idle gap
        @(posedge clk_28);
        r = rand_bits(30);
        smp = audio_pkg::stereo_t'(r[29:0]);
        sample_in  <= smp;
        sample_req <= 1'b1;
        own_l = swap ? smp.right : smp.left;
        own_r = swap ? smp.left : smp.right;
        exp_l = mix_side(own_l, own_r, center);
        exp_r = mix_side(own_r, own_l, center);
        wait_ack(1'b1, n);
        check(n, 1, "ack rise latency");
        check(int'(left_out), exp_l, "left_out");
        check(int'(right_out), exp_r, "right_out");
        @(posedge clk_28);
        r = rand_bits(30);
        sample_req <= 1'b0;
        sample_in  <= audio_pkg::stereo_t'(r[29:0]);  // Source lets go of the data
        wait_ack(1'b0, n);
        check(n, 1, "ack fall latency");
        check(int'(left_out), exp_l, "left_out held");
        check(int'(right_out), exp_r, "right_out held");
      end
    end

    // Track digits and activity LEDs, cycle by cycle
    trk_prev = track;
    act_prev = drive_act;
    for (int b = 0; b < 4; b++) begin
      since_last[b] = STRETCH_CYCLES;       // No recent activity
    end
    for (int i = 0; i < 600; i++) begin
      @(posedge clk_28);
      r = rand_bits(32);
      for (int b = 0; b < 4; b++) begin
        act_new[b] = &r[8 + 6*b +: 6];      // About one pulse in 64 cycles
        since_last[b] = act_prev[b] ? 0 : since_last[b] + 1;
        exp_led[b] = since_last[b] < STRETCH_CYCLES;
      end
      track     <= r[7:0];
      drive_act <= board_pkg::drive_act_t'(act_new);
      @(negedge clk_28);
      check(32'(hex0), 32'(seg_of(trk_prev[3:0])), "hex0");
      check(32'(hex1), 32'(seg_of(trk_prev[7:4])), "hex1");
      check(32'(led_g), 32'(exp_led), "led_g");
      trk_prev = r[7:0];
      act_prev = act_new;
    end

    $display("All tests passed");
    $finish;
  end

endmodule

//--- minimig_board.f
src/board_pkg.sv
src/audio_pkg.sv
src/board_controls.sv
src/reset_seq.sv
src/audio_mixer.sv
src/status_display.sv
src/minimig_board.sv
bench/tb_minimig_board.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_minimig_board
FILELIST  := minimig_board.f
VFLAGS    := --timing --assert --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
